/* design/tank_field_pkg.sv */
/*
 * shared types for the tank field core
 * grid and score widths, facing direction, apb offsets and field positions
 */
`default_nettype none

package tank_field_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int coord_w = 5;	// one grid coordinate
	localparam int score_w = 8;	// kill score and player hit counter

	// ------------------------------
	// facing
	// ------------------------------
	// up decreases y, down increases y
	typedef enum logic [1:0]
	{
		dir_up    = 2'd0,
		dir_down  = 2'd1,
		dir_left  = 2'd2,
		dir_right = 2'd3
	} dir_e;

	// ------------------------------
	// apb word offsets
	// ------------------------------
	typedef enum logic [4:0]
	{
		reg_ctrl   = 5'h00,	// enable, spawn_en, spawn_corner
		reg_player = 5'h04,	// player cell
		reg_pshell = 5'h08,	// player shell valid and cell
		reg_enemy  = 5'h0C,	// read only enemy status
		reg_score  = 5'h10	// read only score and hits
	} reg_addr_e;

	// bit positions inside the register words
	localparam int ctrl_enable_bit  = 0;
	localparam int ctrl_spawn_bit   = 1;
	localparam int ctrl_corner_lsb  = 2;	// two bits
	localparam int pos_x_lsb        = 0;	// x field of any cell word
	localparam int pos_y_lsb        = 8;	// y field of any cell word
	localparam int pshell_valid_bit = 16;
	localparam int enemy_dir_lsb    = 16;	// two bits
	localparam int enemy_alive_bit  = 24;
	localparam int hits_lsb         = 8;	// score sits at bit 0

endpackage

`default_nettype wire

/* design/game_tick_gen.sv */
/*
 * move and shell tick enables derived from clk
 */
`timescale 1ns/100ps
`default_nettype none

module game_tick_gen #(
	parameter int move_div  = 16,	// clk cycles per move tick
	parameter int shell_div = 8	// clk cycles per shell tick
) (
	input  logic clk,
	input  logic rst_n,
	input  logic enable,
	output logic move_tick,
	output logic shell_tick
);

	localparam int max_div = (move_div > shell_div) ? move_div : shell_div;
	localparam int cnt_w   = $clog2(max_div + 1);

	logic [1:0] ticks;	// [0] move, [1] shell

	for (genvar i = 0; i < 2; i++)
	begin : g_div
		localparam int div_i = (i == 0) ? move_div : shell_div;
		localparam logic [cnt_w-1:0] last = cnt_w'(div_i - 1);

		logic [cnt_w-1:0] cnt;	// free running period counter

		always_ff @(posedge clk or negedge rst_n)
		begin
			if (!rst_n)
				cnt <= '0;
			else if (!enable)
				cnt <= '0;	// game paused, restart period
			else if (cnt == last)
				cnt <= '0;	// wrap
			else
				cnt <= cnt + 1'b1;
		end

		assign ticks[i] = enable && (cnt == last);	// last count of the period

		// a tick is a single cycle strobe
		a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
			ticks[i] |=> !ticks[i]);
	end

	assign move_tick  = ticks[0];
	assign shell_tick = ticks[1];

endmodule

`default_nettype wire

/* design/enemy_tank.sv */
/*
 * enemy tank: aim stage, corner spawn, one cell pursuit per move tick
 * hit detection against player and player shell, kill score, fire request
 */
`timescale 1ns/100ps
`default_nettype none

module enemy_tank
	import tank_field_pkg::*;
#(
	parameter int field_w = 17,	// grid columns
	parameter int field_h = 21	// grid rows
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               enable,
	input  logic               move_tick,
	input  logic               spawn_en,
	input  logic [1:0]         spawn_corner,	// bit0 right edge, bit1 bottom edge
	input  logic [coord_w-1:0] player_x,
	input  logic [coord_w-1:0] player_y,
	input  logic               pshell_valid,
	input  logic [coord_w-1:0] pshell_x,
	input  logic [coord_w-1:0] pshell_y,
	output logic               enemy_alive,
	output logic [coord_w-1:0] enemy_x,
	output logic [coord_w-1:0] enemy_y,
	output dir_e               enemy_dir,
	output logic               fire_req,
	output logic [score_w-1:0] score
);

	localparam logic [coord_w-1:0] x_max = coord_w'(field_w - 1);
	localparam logic [coord_w-1:0] y_max = coord_w'(field_h - 1);

	// aim stage
	logic [coord_w-1:0] h_dis;	// horizontal distance
	logic [coord_w-1:0] v_dis;	// vertical distance
	logic               player_right;	// player x above ours
	logic               player_below;	// player y above ours
	logic               eql;	// same cell

	// step decision
	logic level;	// in line on exactly one axis
	logic go_vert;
	dir_e step_dir;
	logic can_step;	// step stays on the grid
	logic hit;

	// same cell or one of the four neighbours
	function automatic logic near(
		input logic [coord_w-1:0] ax,
		input logic [coord_w-1:0] ay,
		input logic [coord_w-1:0] bx,
		input logic [coord_w-1:0] by
	);
		logic [coord_w-1:0] dx;
		logic [coord_w-1:0] dy;
		dx = (ax > bx) ? ax - bx : bx - ax;
		dy = (ay > by) ? ay - by : by - ay;
		return (dx + dy) <= 1;	// 32 bit sum, no wrap
	endfunction

	// ------------------------------
	// aim stage, one clk behind
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_dis        <= '0;
			v_dis        <= '0;
			player_right <= 1'b0;
			player_below <= 1'b0;
			eql          <= 1'b0;
		end
		else
		begin
			h_dis        <= (player_x > enemy_x) ? player_x - enemy_x : enemy_x - player_x;
			v_dis        <= (player_y > enemy_y) ? player_y - enemy_y : enemy_y - player_y;
			player_right <= player_x > enemy_x;
			player_below <= player_y > enemy_y;
			eql          <= (player_x == enemy_x) && (player_y == enemy_y);
		end
	end

	// ------------------------------
	// step choice
	// ------------------------------
	always_comb
	begin
		level   = (h_dis == '0) != (v_dis == '0);
		// vertical when level in x, or when v is the smaller distance, tie goes vertical
		go_vert = (h_dis == '0) || ((v_dis != '0) && (v_dis <= h_dis));
		if (go_vert)
			step_dir = player_below ? dir_down : dir_up;
		else
			step_dir = player_right ? dir_right : dir_left;
		case (step_dir)
			dir_up:   can_step = (enemy_y != '0);
			dir_down: can_step = (enemy_y != y_max);
			dir_left: can_step = (enemy_x != '0);
			default:  can_step = (enemy_x != x_max);
		endcase
	end

	// player body or live player shell touching us
	assign hit = near(enemy_x, enemy_y, player_x, player_y) ||
		(pshell_valid && near(enemy_x, enemy_y, pshell_x, pshell_y));

	// shoot along the line when level, same tick as the decision
	assign fire_req = move_tick && enemy_alive && !hit && level;

	// ------------------------------
	// spawn, hit, move
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			enemy_alive <= 1'b0;
			enemy_x     <= '0;
			enemy_y     <= '0;
			enemy_dir   <= dir_up;
			score       <= '0;
		end
		else if (!enable)
		begin
			enemy_alive <= 1'b0;	// idle while paused
			score       <= '0;
		end
		else if (move_tick)
		begin
			if (!enemy_alive)
			begin
				if (spawn_en)
				begin
					enemy_alive <= 1'b1;
					enemy_x     <= spawn_corner[0] ? x_max : '0;
					enemy_y     <= spawn_corner[1] ? y_max : '0;
					enemy_dir   <= spawn_corner[1] ? dir_up : dir_down;	// face the field
				end
			end
			else if (hit)
			begin
				enemy_alive <= 1'b0;	// killed, wins over the step
				score       <= score + 1'b1;
			end
			else if (!eql)
			begin
				enemy_dir <= step_dir;	// turn even when blocked
				if (can_step)
				begin
					case (step_dir)
						dir_up:   enemy_y <= enemy_y - 1'b1;
						dir_down: enemy_y <= enemy_y + 1'b1;
						dir_left: enemy_x <= enemy_x - 1'b1;
						default:  enemy_x <= enemy_x + 1'b1;
					endcase
				end
			end
		end
	end

	// live tank never wanders off the grid
	a_on_grid: assert property (@(posedge clk) disable iff (!rst_n)
		enemy_alive |-> (enemy_x <= x_max) && (enemy_y <= y_max));

endmodule

`default_nettype wire

/* design/enemy_shell.sv */
/*
 * enemy shell FSM: launch on fire request, flight per shell tick
 * border loss and player hit counter
 */
`timescale 1ns/100ps
`default_nettype none

module enemy_shell
	import tank_field_pkg::*;
#(
	parameter int field_w = 17,
	parameter int field_h = 21
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               enable,
	input  logic               shell_tick,
	input  logic               fire_req,
	input  logic [coord_w-1:0] enemy_x,
	input  logic [coord_w-1:0] enemy_y,
	input  dir_e               enemy_dir,
	input  logic [coord_w-1:0] player_x,
	input  logic [coord_w-1:0] player_y,
	output logic               shell_busy,
	output logic [score_w-1:0] player_hits
);

	localparam logic [coord_w-1:0] x_max = coord_w'(field_w - 1);
	localparam logic [coord_w-1:0] y_max = coord_w'(field_h - 1);

	typedef enum logic {shell_idle, shell_flying} shell_state_e;

	shell_state_e       state;
	logic [coord_w-1:0] sx;	// current shell cell
	logic [coord_w-1:0] sy;
	dir_e               sdir;	// flight direction, fixed at launch
	logic [coord_w-1:0] nx;	// next cell
	logic [coord_w-1:0] ny;
	logic               off_grid;	// next step leaves the field
	logic               launch;
	logic               on_player;

	assign shell_busy = (state == shell_flying);
	assign launch     = (state == shell_idle) && fire_req;	// requests while busy are lost
	assign on_player  = (nx == player_x) && (ny == player_y);

	always_comb
	begin
		nx       = sx;
		ny       = sy;
		off_grid = 1'b0;
		case (sdir)
			dir_up:
			begin
				off_grid = (sy == '0);
				ny       = sy - 1'b1;
			end
			dir_down:
			begin
				off_grid = (sy == y_max);
				ny       = sy + 1'b1;
			end
			dir_left:
			begin
				off_grid = (sx == '0);
				nx       = sx - 1'b1;
			end
			default:
			begin
				off_grid = (sx == x_max);
				nx       = sx + 1'b1;
			end
		endcase
	end

	// ------------------------------
	// state and hit count
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state       <= shell_idle;
			player_hits <= '0;
		end
		else if (!enable)
		begin
			state       <= shell_idle;
			player_hits <= '0;
		end
		else if (launch)
			state <= shell_flying;
		else if (shell_busy && shell_tick)
		begin
			if (off_grid)
				state <= shell_idle;	// lost at the border
			else if (on_player)
			begin
				state       <= shell_idle;	// lands on the player
				player_hits <= player_hits + 1'b1;
			end
		end
	end

	// cell and direction, taken from the tank at launch
	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			sx   <= enemy_x;
			sy   <= enemy_y;
			sdir <= enemy_dir;
		end
		else if (shell_busy && shell_tick)
		begin
			sx <= nx;
			sy <= ny;
		end
	end

	// a request during flight leaves the launch direction alone
	a_no_relaunch: assert property (@(posedge clk) disable iff (!rst_n)
		shell_busy && fire_req |=> $stable(sdir));

endmodule

`default_nettype wire

/* design/field_apb_regs.sv */
/*
 * APB3 slave with control, player and player shell registers
 * status readback of enemy, score and player hits
 */
`timescale 1ns/100ps
`default_nettype none

module field_apb_regs
	import tank_field_pkg::*;
#(
	parameter int field_w = 17,
	parameter int field_h = 21
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [4:0]         paddr,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [31:0]        pwdata,
	input  logic               enemy_alive,
	input  dir_e               enemy_dir,
	input  logic [coord_w-1:0] enemy_x,
	input  logic [coord_w-1:0] enemy_y,
	input  logic [score_w-1:0] score,
	input  logic [score_w-1:0] player_hits,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr,
	output logic               enable,
	output logic               spawn_en,
	output logic [1:0]         spawn_corner,
	output logic [coord_w-1:0] player_x,
	output logic [coord_w-1:0] player_y,
	output logic               pshell_valid,
	output logic [coord_w-1:0] pshell_x,
	output logic [coord_w-1:0] pshell_y
);

	localparam logic [coord_w-1:0] x_max = coord_w'(field_w - 1);
	localparam logic [coord_w-1:0] y_max = coord_w'(field_h - 1);

	logic               access;	// apb access phase
	logic               wr_en;
	logic               addr_ok;	// mapped offset
	logic               addr_ro;	// status offset
	logic [coord_w-1:0] wr_x;
	logic [coord_w-1:0] wr_y;

	assign access = psel && penable;
	assign pready = 1'b1;	// zero wait states
	assign wr_x   = pwdata[pos_x_lsb +: coord_w];
	assign wr_y   = pwdata[pos_y_lsb +: coord_w];

	// ------------------------------
	// decode and read mux
	// ------------------------------
	always_comb
	begin
		prdata  = '0;
		addr_ok = 1'b1;
		addr_ro = 1'b0;
		case (paddr)
			reg_ctrl:
			begin
				prdata[ctrl_enable_bit]      = enable;
				prdata[ctrl_spawn_bit]       = spawn_en;
				prdata[ctrl_corner_lsb +: 2] = spawn_corner;
			end
			reg_player:
			begin
				prdata[pos_x_lsb +: coord_w] = player_x;
				prdata[pos_y_lsb +: coord_w] = player_y;
			end
			reg_pshell:
			begin
				prdata[pos_x_lsb +: coord_w] = pshell_x;
				prdata[pos_y_lsb +: coord_w] = pshell_y;
				prdata[pshell_valid_bit]     = pshell_valid;
			end
			reg_enemy:
			begin
				addr_ro                      = 1'b1;
				prdata[pos_x_lsb +: coord_w] = enemy_x;
				prdata[pos_y_lsb +: coord_w] = enemy_y;
				prdata[enemy_dir_lsb +: 2]   = enemy_dir;
				prdata[enemy_alive_bit]      = enemy_alive;
			end
			reg_score:
			begin
				addr_ro                     = 1'b1;
				prdata[score_w-1:0]         = score;
				prdata[hits_lsb +: score_w] = player_hits;
			end
			default: addr_ok = 1'b0;	// hole in the map
		endcase
	end

	assign pslverr = access && (!addr_ok || (pwrite && addr_ro));
	assign wr_en   = access && pwrite && !pslverr;	// errored writes change nothing

	// ------------------------------
	// writable fields
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			enable       <= 1'b0;
			spawn_en     <= 1'b0;
			spawn_corner <= 2'd0;
			player_x     <= '0;
			player_y     <= '0;
			pshell_valid <= 1'b0;
			pshell_x     <= '0;
			pshell_y     <= '0;
		end
		else if (wr_en)
		begin
			case (paddr)
				reg_ctrl:
				begin
					enable       <= pwdata[ctrl_enable_bit];
					spawn_en     <= pwdata[ctrl_spawn_bit];
					spawn_corner <= pwdata[ctrl_corner_lsb +: 2];
				end
				reg_player:
				begin
					player_x <= (wr_x > x_max) ? x_max : wr_x;	// clamp to grid
					player_y <= (wr_y > y_max) ? y_max : wr_y;
				end
				reg_pshell:
				begin
					pshell_valid <= pwdata[pshell_valid_bit];
					pshell_x     <= wr_x;
					pshell_y     <= wr_y;
				end
				default: ;
			endcase
		end
	end

	// access phase must follow a setup phase
	a_apb_setup: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(penable) |-> $past(psel));

endmodule

`default_nettype wire

/* design/tank_field_top.sv */
/*
 * tank field core top: register block, tick generator, enemy tank and shell
 */
`timescale 1ns/100ps
`default_nettype none

module tank_field_top
	import tank_field_pkg::*;
#(
	parameter int field_w   = 17,	// grid columns
	parameter int field_h   = 21,	// grid rows
	parameter int move_div  = 16,	// clk per move tick
	parameter int shell_div = 8	// clk per shell tick
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	// control from the register block
	logic               enable;
	logic               spawn_en;
	logic [1:0]         spawn_corner;
	logic [coord_w-1:0] player_x;
	logic [coord_w-1:0] player_y;
	logic               pshell_valid;
	logic [coord_w-1:0] pshell_x;
	logic [coord_w-1:0] pshell_y;

	// game state
	logic               move_tick;
	logic               shell_tick;
	logic               enemy_alive;
	logic [coord_w-1:0] enemy_x;
	logic [coord_w-1:0] enemy_y;
	dir_e               enemy_dir;
	logic               fire_req;
	logic               shell_busy;	// status only, no back-pressure
	logic [score_w-1:0] score;
	logic [score_w-1:0] player_hits;

	field_apb_regs #(.field_w(field_w), .field_h(field_h)) u_regs (
		.clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
		.enemy_alive, .enemy_dir, .enemy_x, .enemy_y, .score, .player_hits,
		.prdata, .pready, .pslverr,
		.enable, .spawn_en, .spawn_corner, .player_x, .player_y,
		.pshell_valid, .pshell_x, .pshell_y
	);

	game_tick_gen #(.move_div(move_div), .shell_div(shell_div)) u_ticks (
		.clk, .rst_n, .enable, .move_tick, .shell_tick
	);

	enemy_tank #(.field_w(field_w), .field_h(field_h)) u_tank (
		.clk, .rst_n, .enable, .move_tick, .spawn_en, .spawn_corner,
		.player_x, .player_y, .pshell_valid, .pshell_x, .pshell_y,
		.enemy_alive, .enemy_x, .enemy_y, .enemy_dir, .fire_req, .score
	);

	enemy_shell #(.field_w(field_w), .field_h(field_h)) u_shell (
		.clk, .rst_n, .enable, .shell_tick, .fire_req,
		.enemy_x, .enemy_y, .enemy_dir, .player_x, .player_y,
		.shell_busy, .player_hits
	);

endmodule

`default_nettype wire

/* dv/tank_field_tb.sv */
/*
 * tank field core testbench: APB tasks, LFSR player cells, pursuit model
 * shell path model, concurrent checks and watchdog
 */
`timescale 1ns/100ps
`default_nettype none

module tank_field_tb
	import tank_field_pkg::*;
();

	localparam int field_w       = 17;
	localparam int field_h       = 21;
	localparam int move_div      = 16;
	localparam int shell_div     = 8;
	localparam int clk_period    = 40;	// ns
	localparam int pursuit_ticks = 48;
	localparam int planned_ticks = 200;	// spawn, pursuit, kills, shell flights, pauses
	localparam int margin_ns     = 100000;

	logic        clk;
	logic        rst_n;
	logic [4:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] lfsr;	// stimulus source
	logic        e_alive;	// last enemy status read over APB
	dir_e        e_dir;
	int          e_x;
	int          e_y;
	int          e_score;
	int          e_hits;
	int          plr_x;	// player cell after clamping
	int          plr_y;
	int          corner_sel;

	tank_field_top #(
		.field_w(field_w), .field_h(field_h), .move_div(move_div), .shell_div(shell_div)
	) UUT (
		.clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clk_period / 2) clk = ~clk;
	end

	// ------------------------------
	// failure reporting
	// ------------------------------
	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string msg);
		stop_with_failure($sformatf("Mismatch at %0d ns: %s", $time, msg));
	endtask

	// galois form, taps 32,22,2,1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++)
		begin
			val  = (val << 1) | lfsr[0];	// one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// ------------------------------
	// APB host, inputs move on negedge
	// ------------------------------
	task automatic apb_access(input logic [4:0] addr, input logic wr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge clk);
		paddr   = addr;	// setup phase
		pwrite  = wr;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;	// access phase
		#(clk_period / 4);	// between edges
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	function automatic logic [31:0] cell_word(input int x, input int y);
		logic [31:0] w;
		w = '0;
		w[pos_x_lsb +: coord_w] = x[coord_w-1:0];
		w[pos_y_lsb +: coord_w] = y[coord_w-1:0];
		return w;
	endfunction

	task automatic write_ctrl(input logic en, input logic spawn, input int corner);
		logic [31:0] w;
		logic [31:0] d;
		logic        err;
		w = '0;
		w[ctrl_enable_bit]      = en;
		w[ctrl_spawn_bit]       = spawn;
		w[ctrl_corner_lsb +: 2] = corner[1:0];
		apb_access(reg_ctrl, 1'b1, w, d, err);
		assert (!err) else report_mismatch("pslverr on control write");
	endtask

	task automatic write_pshell(input logic valid, input int x, input int y);
		logic [31:0] w;
		logic [31:0] d;
		logic        err;
		w = cell_word(x, y);
		w[pshell_valid_bit] = valid;
		apb_access(reg_pshell, 1'b1, w, d, err);
		assert (!err) else report_mismatch("pslverr on player shell write");
	endtask

	// writes the player cell and checks the clamped readback
	task automatic write_player(input int x, input int y);
		logic [31:0] d;
		logic        err;
		apb_access(reg_player, 1'b1, cell_word(x, y), d, err);
		assert (!err) else report_mismatch("pslverr on player write");
		plr_x = (x > field_w - 1) ? field_w - 1 : x;
		plr_y = (y > field_h - 1) ? field_h - 1 : y;
		apb_access(reg_player, 1'b0, '0, d, err);
		assert (d[pos_x_lsb +: coord_w] == plr_x && d[pos_y_lsb +: coord_w] == plr_y)
		else report_mismatch($sformatf("player read (%0d,%0d) expected (%0d,%0d)",
			d[pos_x_lsb +: coord_w], d[pos_y_lsb +: coord_w], plr_x, plr_y));
	endtask

	task automatic read_enemy;
		logic [31:0] d;
		logic        err;
		apb_access(reg_enemy, 1'b0, '0, d, err);
		assert (!err) else report_mismatch("pslverr on enemy status read");
		e_alive = d[enemy_alive_bit];
		e_dir   = dir_e'(d[enemy_dir_lsb +: 2]);
		e_x     = d[pos_x_lsb +: coord_w];
		e_y     = d[pos_y_lsb +: coord_w];
	endtask

	task automatic read_score;
		logic [31:0] d;
		logic        err;
		apb_access(reg_score, 1'b0, '0, d, err);
		assert (!err) else report_mismatch("pslverr on score read");
		e_score = d[score_w-1:0];
		e_hits  = d[hits_lsb +: score_w];
	endtask

	task automatic expect_slverr(input logic [4:0] addr, input logic wr);
		logic [31:0] d;
		logic        err;
		apb_access(addr, wr, 32'hFFFF_FFFF, d, err);
		assert (err) else report_mismatch($sformatf("no pslverr at offset 0x%02h", addr));
	endtask

	// ------------------------------
	// tick waits with their own limits
	// ------------------------------
	task automatic wait_move_tick;
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > 2 * move_div)
				stop_with_failure("no move tick arrived within two tick periods");
		end
		while (!UUT.move_tick);
		@(negedge clk);	// tick has been taken
	endtask

	task automatic wait_shell_idle;
		int n;
		n = 0;
		while (UUT.shell_busy)
		begin
			@(negedge clk);
			n++;
			if (n > (field_w + field_h) * shell_div)
				stop_with_failure("enemy shell never returned to idle");
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic int abs_diff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic bit touching(input int ax, input int ay, input int bx, input int by);
		return abs_diff(ax, bx) + abs_diff(ay, by) <= 1;	// same cell or a neighbour
	endfunction

	// corner index order (0,0) (w-1,0) (0,h-1) (w-1,h-1)
	function automatic int corner_x(input int c);
		return (c % 2 == 1) ? field_w - 1 : 0;
	endfunction

	function automatic int corner_y(input int c);
		return (c >= 2) ? field_h - 1 : 0;
	endfunction

	// level on one axis moves along the other, else shorter nonzero distance, tie vertical
	task automatic predict_step(input int x, input int y, output dir_e d, output int nx,
		output int ny);
		int  dx;
		int  dy;
		bit  vertical;
		dx = abs_diff(x, plr_x);
		dy = abs_diff(y, plr_y);
		if (dx == 0)
			vertical = 1'b1;
		else if (dy == 0)
			vertical = 1'b0;
		else
			vertical = (dy <= dx);
		nx = x;
		ny = y;
		if (vertical)
		begin
			d  = (plr_y > y) ? dir_down : dir_up;
			ny = (plr_y > y) ? y + 1 : y - 1;
		end
		else
		begin
			d  = (plr_x > x) ? dir_right : dir_left;
			nx = (plr_x > x) ? x + 1 : x - 1;
		end
	endtask

	// walks the shell from the launch cell, true when it meets the player
	function automatic bit shell_path_hits(input int x, input int y, input dir_e d);
		int cx;
		int cy;
		cx = x;
		cy = y;
		for (int i = 0; i < field_w + field_h; i++)
		begin
			case (d)
				dir_up:    cy--;
				dir_down:  cy++;
				dir_left:  cx--;
				default:   cx++;
			endcase
			if (cx < 0 || cy < 0 || cx >= field_w || cy >= field_h)
				return 1'b0;	// lost at the border
			if (cx == plr_x && cy == plr_y)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// ------------------------------
	// scenarios
	// ------------------------------
	task automatic check_registers;
		logic [31:0] d;
		logic        err;
		write_ctrl(1'b0, 1'b1, 3);
		apb_access(reg_ctrl, 1'b0, '0, d, err);
		assert (!err && !d[ctrl_enable_bit] && d[ctrl_spawn_bit] && d[ctrl_corner_lsb +: 2] == 3)
		else report_mismatch($sformatf("control read 0x%08h", d));
		write_player(31, 31);	// clamps to the far corner
		write_player(5, 7);
		write_pshell(1'b1, 9, 30);
		expect_slverr(5'h14, 1'b1);	// holes in the map
		expect_slverr(5'h1C, 1'b0);
		expect_slverr(5'h02, 1'b1);
		expect_slverr(reg_enemy, 1'b1);	// status is read only
		expect_slverr(reg_score, 1'b1);
		apb_access(reg_pshell, 1'b0, '0, d, err);
		assert (d[pshell_valid_bit] && d[pos_x_lsb +: coord_w] == 9 &&
			d[pos_y_lsb +: coord_w] == 30)
		else report_mismatch($sformatf("player shell read 0x%08h", d));
		apb_access(reg_player, 1'b0, '0, d, err);
		assert (d[pos_x_lsb +: coord_w] == 5 && d[pos_y_lsb +: coord_w] == 7)
		else report_mismatch($sformatf("player read 0x%08h after bad writes", d));
		apb_access(reg_ctrl, 1'b0, '0, d, err);
		assert (!d[ctrl_enable_bit] && d[ctrl_spawn_bit] && d[ctrl_corner_lsb +: 2] == 3)
		else report_mismatch($sformatf("control read 0x%08h after bad writes", d));
		read_enemy();
		read_score();
		assert (!e_alive && e_score == 0 && e_hits == 0)
		else report_mismatch("status not idle after bad writes");
		write_pshell(1'b0, 0, 0);
		write_ctrl(1'b0, 1'b0, 0);
	endtask

	task automatic check_spawn;
		for (int c = 0; c < 4; c++)
		begin
			write_ctrl(1'b0, 1'b0, 0);	// pause drops the tank
			write_player(8, 10);
			write_ctrl(1'b1, 1'b1, c);
			wait_move_tick();
			read_enemy();
			assert (e_alive && e_x == corner_x(c) && e_y == corner_y(c))
			else report_mismatch($sformatf("corner %0d spawn gave alive %0b at (%0d,%0d)",
				c, e_alive, e_x, e_y));
		end
		write_ctrl(1'b0, 1'b0, 0);
	endtask

	task automatic pursue_one_tick;
		logic a0;
		int   x0;
		int   y0;
		int   s0;
		dir_e d_exp;
		int   x_exp;
		int   y_exp;
		a0 = e_alive;
		x0 = e_x;
		y0 = e_y;
		s0 = e_score;
		wait_move_tick();
		read_enemy();
		read_score();
		if (!a0)
		begin
			assert (e_alive && e_x == corner_x(corner_sel) && e_y == corner_y(corner_sel))
			else report_mismatch($sformatf("respawn at (%0d,%0d)", e_x, e_y));
		end
		else if (touching(x0, y0, plr_x, plr_y))
		begin
			assert (!e_alive && e_score == s0 + 1 && e_x == x0 && e_y == y0)
			else report_mismatch("tank touching the player was not killed");
		end
		else
		begin
			predict_step(x0, y0, d_exp, x_exp, y_exp);
			assert (e_alive && e_x == x_exp && e_y == y_exp && e_dir == d_exp)
			else report_mismatch($sformatf("step (%0d,%0d)->(%0d,%0d) %s, expected (%0d,%0d) %s",
				x0, y0, e_x, e_y, e_dir.name(), x_exp, y_exp, d_exp.name()));
			assert (abs_diff(e_x, plr_x) + abs_diff(e_y, plr_y) ==
				abs_diff(x0, plr_x) + abs_diff(y0, plr_y) - 1)
			else report_mismatch("distance to the player did not shrink by one");
		end
	endtask

	task automatic chase_player;
		int px;
		int py;
		write_pshell(1'b0, 0, 0);
		rand_bits(2, corner_sel);
		rand_bits(5, px);
		rand_bits(5, py);
		write_player(px, py);
		write_ctrl(1'b1, 1'b1, corner_sel);
		read_enemy();
		read_score();
		for (int t = 0; t < pursuit_ticks; t++)
		begin
			pursue_one_tick();
			if (t % 12 == 11)
			begin
				rand_bits(5, px);	// new target
				rand_bits(5, py);
				write_player(px, py);
			end
		end
		write_ctrl(1'b0, 1'b0, 0);
	endtask

	// shell on a neighbour cell, then the dead tank must stay put
	task automatic kill_with_pshell;
		int s0;
		int x0;
		int y0;
		read_enemy();
		read_score();
		s0 = e_score;
		x0 = e_x;
		y0 = e_y;
		write_pshell(1'b1, (x0 > 0) ? x0 - 1 : x0 + 1, y0);
		wait_move_tick();
		read_enemy();
		read_score();
		assert (!e_alive && e_score == s0 + 1)
		else report_mismatch($sformatf("kill gave alive %0b score %0d", e_alive, e_score));
		write_pshell(1'b0, 0, 0);
		wait_move_tick();
		read_enemy();
		assert (!e_alive && e_x == x0 && e_y == y0)
		else report_mismatch("dead tank moved or came back");
	endtask

	task automatic run_fire_case(input int c, input int px, input int py);
		int   lx;
		int   ly;
		dir_e ld;
		bit   level;
		int   exp_hits;
		write_ctrl(1'b0, 1'b0, 0);
		write_pshell(1'b0, 0, 0);
		write_player(px, py);
		write_ctrl(1'b1, 1'b1, c);
		wait_move_tick();	// spawn
		write_ctrl(1'b1, 1'b0, c);	// no respawn after the kill
		read_enemy();
		lx    = e_x;
		ly    = e_y;
		ld    = e_dir;	// facing at the firing tick
		level = (lx == plr_x) != (ly == plr_y);
		wait_move_tick();
		assert (UUT.shell_busy == level)
		else report_mismatch($sformatf("shell busy %0b, level %0b", UUT.shell_busy, level));
		exp_hits = (level && shell_path_hits(lx, ly, ld)) ? 1 : 0;
		kill_with_pshell();
		wait_shell_idle();
		read_score();
		assert (e_hits == exp_hits)
		else report_mismatch($sformatf("player hits %0d expected %0d", e_hits, exp_hits));
	endtask

	task automatic check_disable;
		read_score();
		assert (e_score > 0 && e_hits > 0)
		else report_mismatch("nothing to clear before the pause");
		write_ctrl(1'b0, 1'b0, 0);
		read_score();
		assert (e_score == 0 && e_hits == 0)
		else report_mismatch($sformatf("pause left score %0d hits %0d", e_score, e_hits));
		repeat (3 * move_div) @(negedge clk);	// tick checks run meanwhile
		read_enemy();
		assert (!e_alive) else report_mismatch("tank alive while paused");
	endtask

	// ------------------------------
	// concurrent checks
	// ------------------------------
	a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready)
		else report_mismatch("pready dropped");

	a_err_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		!(psel && penable) |-> !pslverr)
		else report_mismatch("pslverr outside an access phase");

	a_paused: assert property (@(posedge clk) disable iff (!rst_n)
		!UUT.enable |-> !UUT.move_tick && !UUT.shell_tick)
		else report_mismatch("tick while disabled");

	a_fire_alive: assert property (@(posedge clk) disable iff (!rst_n)
		UUT.fire_req |-> UUT.enemy_alive && UUT.move_tick)
		else report_mismatch("fire request without a live tank on a move tick");

	a_launch: assert property (@(posedge clk) disable iff (!rst_n)
		UUT.fire_req && !UUT.shell_busy |=> UUT.shell_busy)
		else report_mismatch("idle shell ignored a fire request");

	// ------------------------------
	// sequence and watchdog
	// ------------------------------
	initial
	begin
		rst_n   = 1'b0;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		lfsr    = 32'h146c_f6a6;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (!UUT.move_tick && !UUT.shell_tick && !UUT.shell_busy && !UUT.fire_req)
		else report_mismatch("core not idle after reset");
		check_registers();
		check_spawn();
		chase_player();
		run_fire_case(0, 0, 10);	// straight down onto the player
		run_fire_case(0, 10, 0);	// level in y but facing down
		run_fire_case(1, 8, 10);	// not level, no shot
		run_fire_case(2, 7, 20);
		run_fire_case(3, 16, 5);	// straight up onto the player
		check_disable();
		$display("Result: PASSED");
		$finish;
	end

	initial
	begin
		#(planned_ticks * move_div * clk_period + margin_ns);
		stop_with_failure("Timeout: the test sequence did not finish in the planned time");
	end

endmodule

`default_nettype wire

/* vlog.f */
design/tank_field_pkg.sv
design/game_tick_gen.sv
design/enemy_tank.sv
design/enemy_shell.sv
design/field_apb_regs.sv
design/tank_field_top.sv
dv/tank_field_tb.sv

/* Bender.yml */
package:
  name: tank_field

sources:
  - files:
      - design/tank_field_pkg.sv
      - design/game_tick_gen.sv
      - design/enemy_tank.sv
      - design/enemy_shell.sv
      - design/field_apb_regs.sv
      - design/tank_field_top.sv
  - target: test
    files:
      - dv/tank_field_tb.sv
